/* logic/l2_pkg.sv */
package l2_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 256;
    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 3;
    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W    = 2;
    localparam int PLRU_W   = 3;

    // line write source and pmem address source
    localparam logic LINE_SEL_CPU   = 1'b0;
    localparam logic LINE_SEL_MEM   = 1'b1;
    localparam logic PMEM_SEL_FILL  = 1'b0;
    localparam logic PMEM_SEL_DRAIN = 1'b1;

    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    // [2] half used last, [1] way-1 side of lower half, [0] way-3 side of upper half
    typedef logic [PLRU_W-1:0]   plru_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        line_t             wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        line_t             wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fill,
        st_drain
    } state_t;

endpackage

/* logic/way_store.sv */
`timescale 1ns/1ps

module way_store #(
    parameter type entry_t = l2_pkg::line_t
) (
    input  logic              clk,
    input  logic              rst,
    input  l2_pkg::index_t    index,
    input  l2_pkg::way_mask_t we,
    input  entry_t            wdata,
    output entry_t            rdata [l2_pkg::NUM_WAYS]
);
    import l2_pkg::*;

    entry_t mem [NUM_SETS][NUM_WAYS];

    // reset wipes every entry, so all lines start invalid
    always_ff @(posedge clk)
    begin
        for (int s = 0; s < NUM_SETS; s++)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (rst)
                    mem[s][w] <= '0;
                else if (we[w] && (index_t'(s) == index))
                    mem[s][w] <= wdata;
            end
        end
    end

    // all ways of the addressed set, read async
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
            rdata[w] = mem[index][w];
    end

endmodule

/* logic/plru_tree.sv */
`timescale 1ns/1ps

module plru_tree (
    input  logic           clk,
    input  logic           rst,
    input  l2_pkg::index_t index,
    input  logic           update,
    input  l2_pkg::way_t   used_way,
    output l2_pkg::way_t   victim
);
    import l2_pkg::*;

    plru_t tree [NUM_SETS];
    plru_t cur;

    assign cur = tree[index];

    // mark the used half and the used side within it
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                tree[s] <= '0;
        end
        else if (update)
        begin
            if (!used_way[1])
            begin
                tree[index][2] <= 1'b0;
                tree[index][1] <= used_way[0];
            end
            else
            begin
                tree[index][2] <= 1'b1;
                tree[index][0] <= used_way[0];
            end
        end
    end

    // victim sits in the half not used last
    always_comb
    begin
        if (!cur[2])
            victim = cur[0] ? way_t'(2) : way_t'(3);
        else
            victim = cur[1] ? way_t'(0) : way_t'(1);
    end

endmodule

/* logic/evict_buffer.sv */
`timescale 1ns/1ps

module evict_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      clear,
    input  logic [l2_pkg::ADDR_W-1:0] load_addr,
    input  l2_pkg::line_t             load_line,
    input  logic [l2_pkg::ADDR_W-1:0] probe_addr,
    output logic                      full,
    output logic                      match,
    output logic [l2_pkg::ADDR_W-1:0] addr,
    output l2_pkg::line_t             line
);
    import l2_pkg::*;

    logic [ADDR_W-OFFSET_W-1:0] held_line_addr;
    logic [ADDR_W-OFFSET_W-1:0] probe_line_addr;

    // occupancy flag
    always_ff @(posedge clk)
    begin
        if (rst)
            full <= 1'b0;
        else if (load)
            full <= 1'b1;
        else if (clear)
            full <= 1'b0;
    end

    // evicted line and where it belongs
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            addr <= load_addr;
            line <= load_line;
        end
    end

    // compare on line address, byte offset ignored
    assign held_line_addr  = addr[ADDR_W-1:OFFSET_W];
    assign probe_line_addr = probe_addr[ADDR_W-1:OFFSET_W];

    assign match = full && (held_line_addr == probe_line_addr);

endmodule

/* logic/l2_arrays.sv */
`timescale 1ns/1ps

module l2_arrays (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [l2_pkg::ADDR_W-1:0] addr,
    input  l2_pkg::way_mask_t         meta_we,
    input  l2_pkg::meta_t             meta_wdata,
    input  l2_pkg::way_mask_t         line_we,
    input  logic                      line_wsel,
    input  l2_pkg::line_t             cpu_line,
    input  l2_pkg::line_t             mem_line,
    input  l2_pkg::way_t              dout_way,
    output logic                      hit,
    output l2_pkg::way_t              hit_way,
    output l2_pkg::way_mask_t         valid_mask,
    output l2_pkg::way_mask_t         dirty_mask,
    output l2_pkg::line_t             dout_line,
    output l2_pkg::tag_t              dout_tag
);
    import l2_pkg::*;

    index_t    index;
    tag_t      tag;
    line_t     line_wdata;
    meta_t     meta_rd [NUM_WAYS];
    line_t     line_rd [NUM_WAYS];
    way_mask_t hit_vec;

    // address split
    assign index = addr[OFFSET_W +: INDEX_W];
    assign tag   = addr[ADDR_W-1 -: TAG_W];

    // fill data from memory, write hit data from the cpu
    assign line_wdata = (line_wsel == LINE_SEL_MEM) ? mem_line : cpu_line;

    way_store #(.entry_t(meta_t)) meta_store (
        .clk(clk), .rst(rst), .index(index),
        .we(meta_we), .wdata(meta_wdata), .rdata(meta_rd)
    );

    way_store #(.entry_t(line_t)) line_store (
        .clk(clk), .rst(rst), .index(index),
        .we(line_we), .wdata(line_wdata), .rdata(line_rd)
    );

    // per-way status and tag compare
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            valid_mask[w] = meta_rd[w].valid;
            dirty_mask[w] = meta_rd[w].dirty;
            hit_vec[w]    = meta_rd[w].valid && (meta_rd[w].tag == tag);
        end
    end

    // at most one way matches, lowest index taken anyway
    always_comb
    begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (hit_vec[w])
                hit_way = way_t'(w);
        end
    end

    assign hit = |hit_vec;

    // read-out of the selected way
    assign dout_line = line_rd[dout_way];
    assign dout_tag  = meta_rd[dout_way].tag;

endmodule

/* logic/l2_ctrl.sv */
`timescale 1ns/1ps

module l2_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  l2_pkg::cpu_req_t  cpu_req,
    input  logic              hit,
    input  l2_pkg::way_t      hit_way,
    input  l2_pkg::way_mask_t valid_mask,
    input  l2_pkg::way_mask_t dirty_mask,
    input  l2_pkg::way_t      victim,
    input  logic              ewb_full,
    input  logic              ewb_hit,
    input  logic              pmem_resp,
    output logic              mem_resp,
    output l2_pkg::way_mask_t meta_we,
    output l2_pkg::meta_t     meta_wdata,
    output l2_pkg::way_mask_t line_we,
    output logic              line_wsel,
    output l2_pkg::way_t      dout_way,
    output logic              dout_ewb,
    output logic              plru_update,
    output logic              ewb_load,
    output logic              ewb_clear,
    output logic              pmem_read,
    output logic              pmem_write,
    output logic              pmem_sel
);
    import l2_pkg::*;

    state_t state;
    state_t next_state;
    way_t   alloc_way;
    logic   alloc_dirty;
    tag_t   req_tag;

    // one-hot write enable for a single way
    function automatic way_mask_t way_to_mask(way_t way);
        way_to_mask = way_mask_t'(1) << way;
    endfunction

    assign req_tag = cpu_req.addr[ADDR_W-1 -: TAG_W];

    // lowest invalid way wins, tree victim only when the set is full
    always_comb
    begin
        alloc_way = victim;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_mask[w])
                alloc_way = way_t'(w);
        end
    end

    assign alloc_dirty = valid_mask[alloc_way] && dirty_mask[alloc_way];

    always_comb
    begin
        next_state  = state;
        mem_resp    = 1'b0;
        meta_we     = '0;
        // fills install a valid clean line
        meta_wdata  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
        line_we     = '0;
        line_wsel   = LINE_SEL_CPU;
        dout_way    = alloc_way;
        dout_ewb    = 1'b0;
        plru_update = 1'b0;
        ewb_load    = 1'b0;
        ewb_clear   = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        pmem_sel    = PMEM_SEL_FILL;

        case (state)
            st_idle:
            begin
                // requests first, drain only when the cpu is quiet
                if (cpu_req.read || cpu_req.write)
                    next_state = st_lookup;
                else if (ewb_full)
                    next_state = st_drain;
            end

            st_lookup:
            begin
                if (hit)
                begin
                    mem_resp    = 1'b1;
                    plru_update = 1'b1;
                    dout_way    = hit_way;
                    if (cpu_req.write)
                    begin
                        meta_we          = way_to_mask(hit_way);
                        meta_wdata.dirty = 1'b1;
                        line_we          = way_to_mask(hit_way);
                    end
                    next_state = st_idle;
                end
                else if (cpu_req.read && ewb_hit)
                begin
                    // line still parked in the buffer
                    mem_resp   = 1'b1;
                    dout_ewb   = 1'b1;
                    next_state = st_idle;
                end
                else if (cpu_req.write && ewb_hit)
                    // memory copy is stale until the buffer drains
                    next_state = st_drain;
                else if (alloc_dirty)
                    next_state = ewb_full ? st_drain : st_write_back;
                else
                    next_state = st_fill;
            end

            st_write_back:
            begin
                // move victim into the buffer, then free the way
                ewb_load   = 1'b1;
                meta_we    = way_to_mask(alloc_way);
                meta_wdata = '0;
                next_state = st_fill;
            end

            st_fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    meta_we    = way_to_mask(alloc_way);
                    line_we    = way_to_mask(alloc_way);
                    line_wsel  = LINE_SEL_MEM;
                    // back to lookup, which now hits
                    next_state = st_lookup;
                end
            end

            st_drain:
            begin
                pmem_write = 1'b1;
                pmem_sel   = PMEM_SEL_DRAIN;
                if (pmem_resp)
                begin
                    ewb_clear  = 1'b1;
                    next_state = st_idle;
                end
            end

            default:
                next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= next_state;
    end

endmodule

/* logic/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache (
    input  logic             clk,
    input  logic             rst,
    input  l2_pkg::cpu_req_t cpu_req,
    output logic             mem_resp,
    output l2_pkg::line_t    rdata,
    output l2_pkg::mem_req_t pmem_req,
    input  logic             pmem_resp,
    input  l2_pkg::line_t    pmem_rdata
);
    import l2_pkg::*;

    // array status
    logic              hit;
    way_t              hit_way;
    way_mask_t         valid_mask;
    way_mask_t         dirty_mask;
    line_t             dout_line;
    tag_t              dout_tag;
    way_t              victim;
    // eviction buffer status
    logic              ewb_full;
    logic              ewb_hit;
    logic [ADDR_W-1:0] ewb_addr;
    line_t             ewb_line;
    // controller outputs
    way_mask_t         meta_we;
    meta_t             meta_wdata;
    way_mask_t         line_we;
    logic              line_wsel;
    way_t              dout_way;
    logic              dout_ewb;
    logic              plru_update;
    logic              ewb_load;
    logic              ewb_clear;
    logic              pmem_read;
    logic              pmem_write;
    logic              pmem_sel;
    // address forms
    index_t            req_index;
    logic [ADDR_W-1:0] evict_addr;
    logic [ADDR_W-1:0] fill_addr;

    assign req_index  = cpu_req.addr[OFFSET_W +: INDEX_W];
    // victim line address rebuilt from its stored tag
    assign evict_addr = {dout_tag, req_index, {OFFSET_W{1'b0}}};
    assign fill_addr  = {cpu_req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // drains write the buffered line, fills read the requested line
    assign pmem_req = '{read:  pmem_read,
                        write: pmem_write,
                        addr:  (pmem_sel == PMEM_SEL_DRAIN) ? ewb_addr : fill_addr,
                        wdata: ewb_line};

    assign rdata = dout_ewb ? ewb_line : dout_line;

    l2_ctrl ctrl (
        .clk(clk), .rst(rst), .cpu_req(cpu_req),
        .hit(hit), .hit_way(hit_way), .valid_mask(valid_mask), .dirty_mask(dirty_mask),
        .victim(victim), .ewb_full(ewb_full), .ewb_hit(ewb_hit), .pmem_resp(pmem_resp),
        .mem_resp(mem_resp), .meta_we(meta_we), .meta_wdata(meta_wdata),
        .line_we(line_we), .line_wsel(line_wsel), .dout_way(dout_way), .dout_ewb(dout_ewb),
        .plru_update(plru_update), .ewb_load(ewb_load), .ewb_clear(ewb_clear),
        .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_sel(pmem_sel)
    );

    l2_arrays arrays (
        .clk(clk), .rst(rst), .addr(cpu_req.addr),
        .meta_we(meta_we), .meta_wdata(meta_wdata), .line_we(line_we),
        .line_wsel(line_wsel), .cpu_line(cpu_req.wdata), .mem_line(pmem_rdata),
        .dout_way(dout_way), .hit(hit), .hit_way(hit_way), .valid_mask(valid_mask),
        .dirty_mask(dirty_mask), .dout_line(dout_line), .dout_tag(dout_tag)
    );

    plru_tree plru (
        .clk(clk), .rst(rst), .index(req_index),
        .update(plru_update), .used_way(hit_way), .victim(victim)
    );

    evict_buffer ewb (
        .clk(clk), .rst(rst), .load(ewb_load), .clear(ewb_clear),
        .load_addr(evict_addr), .load_line(dout_line), .probe_addr(cpu_req.addr),
        .full(ewb_full), .match(ewb_hit), .addr(ewb_addr), .line(ewb_line)
    );

endmodule

/* dv/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model #(
    parameter logic [31:0] seed_init = 32'h1
) (
    input  logic             clk,
    input  logic             rst,
    input  l2_pkg::mem_req_t pmem_req,
    output logic             pmem_resp,
    output l2_pkg::line_t    pmem_rdata
);
    import l2_pkg::*;

    // sparse backing store, keyed by line address
    line_t  lines [bit [ADDR_W-1:0]];
    integer seed;
    logic   busy;
    int     wait_left;

    // unwritten lines read back as their own address
    function automatic line_t read_line(logic [ADDR_W-1:0] addr);
        if (lines.exists(addr))
            read_line = lines[addr];
        else
            read_line = {(LINE_W / 32){addr}};
    endfunction

    initial
    begin
        seed       = seed_init;
        busy       = 1'b0;
        wait_left  = 0;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            pmem_resp <= 1'b0;
        end
        else if (pmem_resp)
        begin
            // one-cycle pulse, strobe drops on this same edge
            busy      <= 1'b0;
            pmem_resp <= 1'b0;
        end
        else if (pmem_req.read || pmem_req.write)
        begin
            if (!busy)
            begin
                // new request, pick its latency
                busy      <= 1'b1;
                wait_left <= $unsigned($random(seed)) % 4;
            end
            else if (wait_left != 0)
                wait_left <= wait_left - 1;
            else
            begin
                pmem_resp <= 1'b1;
                if (pmem_req.write)
                    lines[pmem_req.addr] = pmem_req.wdata;
                else
                    pmem_rdata <= read_line(pmem_req.addr);
            end
        end
    end

endmodule

/* dv/l2_cache_assert.sv */
`timescale 1ns/1ps

module l2_cache_assert (
    input logic             clk,
    input logic             rst,
    input logic             mem_resp,
    input l2_pkg::mem_req_t pmem_req,
    input logic             pmem_resp
);

    // memory strobes are exclusive
    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_req.read && pmem_req.write))
        else $error("pmem read and write high together");

    // cpu response is a single-cycle pulse
    resp_single_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp)
        else $error("mem_resp high two cycles running");

    // fill read held until memory answers
    read_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_req.read && !pmem_resp) |=> pmem_req.read)
        else $error("pmem read dropped before pmem_resp");

endmodule

bind l2_cache l2_cache_assert chk (
    .clk(clk), .rst(rst), .mem_resp(mem_resp), .pmem_req(pmem_req), .pmem_resp(pmem_resp)
);

/* dv/l2_cache_tb.sv */
`timescale 1ns/1ps

module l2_cache_tb;
    import l2_pkg::*;

    localparam logic [31:0] seed_init     = 32'hbda9530e;
    localparam int          resp_timeout  = 60;
    localparam int          drain_timeout = 40;
    localparam int          random_ops    = 400;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    logic     mem_resp;
    line_t    rdata;
    mem_req_t pmem_req;
    logic     pmem_resp;
    line_t    pmem_rdata;
    integer   seed;

    // expected cache image
    line_t             written [bit [ADDR_W-1:0]];
    logic [ADDR_W-1:0] way_line  [NUM_SETS][NUM_WAYS];
    way_mask_t         way_valid [NUM_SETS];
    way_mask_t         way_dirty [NUM_SETS];
    plru_t             tree_bits [NUM_SETS];
    logic              buf_valid;
    logic [ADDR_W-1:0] buf_addr;

    // expected responses and drains in issue order
    line_t             resp_data_q  [$];
    bit                resp_check_q [$];
    logic [ADDR_W-1:0] drain_addr_q [$];
    line_t             drain_data_q [$];
    logic              resp_prev;
    logic              read_prev;
    logic              presp_prev;

    l2_cache uut (
        .clk(clk), .rst(rst), .cpu_req(cpu_req), .mem_resp(mem_resp), .rdata(rdata),
        .pmem_req(pmem_req), .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata)
    );

    l2_mem_model #(.seed_init(seed_init)) memory (
        .clk(clk), .rst(rst), .pmem_req(pmem_req),
        .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // unwritten line holds its address in every 32-bit word
    function automatic line_t fill_pattern(logic [ADDR_W-1:0] line_addr);
        fill_pattern = {(LINE_W / 32){line_addr}};
    endfunction

    // reference result for a line read
    function automatic line_t expected_line(logic [ADDR_W-1:0] line_addr);
        if (written.exists(line_addr))
            expected_line = written[line_addr];
        else
            expected_line = fill_pattern(line_addr);
    endfunction

    // victim is the way opposite the recent use at each tree level
    function automatic way_t plru_victim(plru_t t);
        plru_victim = t[2] ? {1'b0, !t[1]} : {1'b1, !t[0]};
    endfunction

    task automatic plru_touch(input index_t s, input way_t w);
        if (!w[1])
        begin
            tree_bits[s][2] = 1'b0;
            tree_bits[s][1] = w[0];
        end
        else
        begin
            tree_bits[s][2] = 1'b1;
            tree_bits[s][0] = w[0];
        end
    endtask

    // buffered line is expected on the memory write port next
    task automatic queue_drain();
        drain_addr_q.push_back(buf_addr);
        drain_data_q.push_back(expected_line(buf_addr));
        buf_valid = 1'b0;
    endtask

    // advance the cache image by one access and flag a fast answer
    task automatic predict(input logic rd, input logic wr, input logic [ADDR_W-1:0] addr,
                           input line_t data, output bit fast);
        logic [ADDR_W-1:0] la;
        index_t            s;
        way_t              w;
        bit                found;
        la    = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        s     = la[OFFSET_W +: INDEX_W];
        found = 1'b0;
        w     = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--)
        begin
            if (way_valid[s][i] && (way_line[s][i] == la))
            begin
                found = 1'b1;
                w     = way_t'(i);
            end
        end
        fast = found;
        if (!found && rd && buf_valid && (buf_addr == la))
        begin
            // read served from the eviction buffer leaves the tree alone
            fast = 1'b1;
            resp_data_q.push_back(expected_line(la));
            resp_check_q.push_back(1'b1);
        end
        else
        begin
            if (!found)
            begin
                // memory copy is stale while the buffer holds this line
                if (wr && buf_valid && (buf_addr == la))
                    queue_drain();
                w = plru_victim(tree_bits[s]);
                for (int i = NUM_WAYS - 1; i >= 0; i--)
                begin
                    if (!way_valid[s][i])
                        w = way_t'(i);
                end
                if (way_valid[s][w] && way_dirty[s][w])
                begin
                    if (buf_valid)
                        queue_drain();
                    buf_valid = 1'b1;
                    buf_addr  = way_line[s][w];
                end
                way_line[s][w]  = la;
                way_valid[s][w] = 1'b1;
                way_dirty[s][w] = 1'b0;
            end
            plru_touch(s, w);
            if (wr)
            begin
                way_dirty[s][w] = 1'b1;
                written[la]     = data;
            end
            resp_data_q.push_back(expected_line(la));
            resp_check_q.push_back(rd);
        end
    endtask

    // one cpu request held until mem_resp
    task automatic do_access(input logic rd, input logic wr, input logic [ADDR_W-1:0] addr,
                             input line_t data);
        bit fast;
        int waited;
        predict(rd, wr, addr, data, fast);
        @(posedge clk);
        cpu_req <= '{read: rd, write: wr, addr: addr, wdata: data};
        @(negedge clk);
        waited = 1;
        while (!mem_resp && (waited < resp_timeout))
        begin
            @(negedge clk);
            waited++;
        end
        assert (mem_resp)
        else fail_now($sformatf("no mem_resp for the request to %h before the timeout", addr));
        // hits answer one cycle after idle samples the request
        if (fast)
            assert (waited == 2)
            else fail_now($sformatf("FAIL %0t: hit on %h took %0d cycles", $time, addr, waited));
    endtask

    // buffered line must reach memory once the cpu goes quiet
    task automatic idle_drain();
        logic [ADDR_W-1:0] a;
        line_t             d;
        int                waited;
        @(posedge clk);
        cpu_req <= '0;
        if (buf_valid)
        begin
            a = buf_addr;
            d = expected_line(a);
            queue_drain();
            waited = 0;
            while ((drain_addr_q.size() != 0) && (waited < drain_timeout))
            begin
                @(negedge clk);
                waited++;
            end
            assert (drain_addr_q.size() == 0)
            else fail_now("the eviction buffer was not drained while the cpu was idle");
            assert (memory.read_line(a) == d)
            else fail_now($sformatf("FAIL %0t: memory line %h differs after drain", $time, a));
        end
    endtask

    task automatic random_line(output line_t l);
        for (int i = 0; i < LINE_W / 32; i++)
            l[i*32 +: 32] = $random(seed);
    endtask

    // response compare and protocol watch at mid-cycle
    always @(negedge clk)
    begin
        line_t exp_line;
        bit    exp_chk;
        if (!rst)
        begin
            assert (!(mem_resp && resp_prev))
            else fail_now("mem_resp stayed high for two cycles");
            assert (!(pmem_req.read && pmem_req.write))
            else fail_now("pmem read and write were high together");
            assert (!(read_prev && !presp_prev && !pmem_req.read))
            else fail_now("pmem read dropped before pmem_resp");
            if (mem_resp)
            begin
                assert (resp_data_q.size() != 0)
                else fail_now("mem_resp arrived with no request outstanding");
                exp_line = resp_data_q.pop_front();
                exp_chk  = resp_check_q.pop_front();
                if (exp_chk)
                    assert (rdata == exp_line)
                    else fail_now($sformatf("FAIL %0t: rdata %h, expected %h",
                                            $time, rdata[31:0], exp_line[31:0]));
            end
        end
        resp_prev  = mem_resp;
        read_prev  = pmem_req.read;
        presp_prev = pmem_resp;
    end

    // each memory write must be the predicted victim with its last data
    always @(negedge clk)
    begin
        logic [ADDR_W-1:0] exp_addr;
        line_t             exp_line;
        if (!rst && pmem_req.write && pmem_resp)
        begin
            assert (drain_addr_q.size() != 0)
            else fail_now("a memory write appeared with no eviction expected");
            exp_addr = drain_addr_q.pop_front();
            exp_line = drain_data_q.pop_front();
            assert (pmem_req.addr == exp_addr)
            else fail_now($sformatf("FAIL %0t: drain address %h, expected %h",
                                    $time, pmem_req.addr, exp_addr));
            assert (pmem_req.wdata == exp_line)
            else fail_now($sformatf("FAIL %0t: drain data for %h is not its last write",
                                    $time, exp_addr));
        end
    end

    initial
    begin
        line_t             d;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] set_addr [6];
        int                pick;
        seed       = seed_init;
        rst        = 1'b1;
        cpu_req    = '0;
        buf_valid  = 1'b0;
        buf_addr   = '0;
        resp_prev  = 1'b0;
        read_prev  = 1'b0;
        presp_prev = 1'b0;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            way_valid[s] = '0;
            way_dirty[s] = '0;
            tree_bits[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++)
                way_line[s][w] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!mem_resp && !pmem_req.read && !pmem_req.write)
        else fail_now($sformatf("FAIL %0t: outputs not quiet after reset", $time));

        // miss fills the pattern and the repeat hits
        do_access(1'b1, 1'b0, 32'h0001_2300, '0);
        do_access(1'b1, 1'b0, 32'h0001_2300, '0);
        // write then read back
        random_line(d);
        do_access(1'b0, 1'b1, 32'h0004_5660, d);
        do_access(1'b1, 1'b0, 32'h0004_5660, '0);

        // six dirty lines in set 2 overflow its four ways
        for (int i = 0; i < 6; i++)
        begin
            set_addr[i] = {TAG_W'(24'h0a0 + i), index_t'(2), {OFFSET_W{1'b0}}};
            random_line(d);
            do_access(1'b0, 1'b1, set_addr[i], d);
        end
        for (int i = 0; i < 6; i++)
            do_access(1'b1, 1'b0, set_addr[i], '0);
        idle_drain();

        // six tags per set keep evictions coming in mixed traffic
        for (int n = 0; n < random_ops; n++)
        begin
            pick                 = $unsigned($random(seed)) % 6;
            a                    = $random(seed);
            a[ADDR_W-1 -: TAG_W] = TAG_W'(24'h0b0 + pick);
            random_line(d);
            if ($random(seed) & 1)
                do_access(1'b0, 1'b1, a, d);
            else
                do_access(1'b1, 1'b0, a, '0);
        end
        idle_drain();
        repeat (4) @(negedge clk);

        if ((resp_data_q.size() == 0) && (drain_addr_q.size() == 0))
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
            fail_now("responses or drains still outstanding at the end of the run");
    end

endmodule

/* files.f */
logic/l2_pkg.sv
logic/way_store.sv
logic/plru_tree.sv
logic/evict_buffer.sv
logic/l2_arrays.sv
logic/l2_ctrl.sv
logic/l2_cache.sv
dv/l2_mem_model.sv
dv/l2_cache_assert.sv
dv/l2_cache_tb.sv
